/* filelist.f */
hdl/fog_pkg.sv
hdl/fog_apb_regs.sv
hdl/fog_mod_gen.sv
hdl/fog_err_demod.sv
hdl/fog_loop_filter.sv
hdl/fog_ctrl_top.sv
tests/tb_fog_ctrl.sv

/* Makefile */
# Verilator build and run for the fog closed-loop core

VERILATOR ?= verilator
TOP       ?= tb_fog_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

test: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx '\*\* PASS \*\*' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR)

/* tests/tb_fog_ctrl.sv */
/*
 * fog core testbench
 * APB access, square-wave sensor model, strobe and loop checks
 */
`default_nettype none

module tb_fog_ctrl;
	timeunit 1ns;
	timeprecision 100ps;
	import fog_pkg::*;

	localparam int HALF_PER = 120;
	localparam int WAIT_CNT = 4;
	localparam int OFFSET = 37;
	localparam logic [15:0] MOD_AMP = 16'h0800;
	localparam int STROBE_TIMEOUT = 6 * HALF_PER;
	// one budget in half-periods per test
	localparam int BUDGET_HALVES = 10 + 10 + 20 + 60 + 20 + 20;
	localparam longint WATCHDOG_NS = 2 * BUDGET_HALVES * HALF_PER * 10;

	logic               i_clk;
	logic               i_rst_n;
	logic               i_psel;
	logic               i_penable;
	logic               i_pwrite;
	addr_t              i_paddr;
	word_t              i_pwdata;
	word_t              o_prdata;
	logic               o_pready;
	logic               o_pslverr;
	logic signed [13:0] i_adc_data;
	logic [15:0]        o_dac_data;
	logic               o_mod_level;
	logic               o_step_sync;
	logic               o_step_sync_dly;
	logic               o_rate_sync;
	logic               o_ramp_sync;

	int          errors;
	int          tests_run;
	int          tests_failed;
	int          dac_checks;
	int          dac_wait;
	int          lo_level;
	int          hi_level;
	err_t        exp_err;
	logic [4:0]  gain_cfg;
	bit          loop_on;
	bit          quiet;
	err_t        model_rate;
	logic [15:0] model_phase;
	logic [15:0] exp_dac;
	logic        last_level;
	logic [15:0] seen_states;

	fog_ctrl_top UUT (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_psel          (i_psel),
		.i_penable       (i_penable),
		.i_pwrite        (i_pwrite),
		.i_paddr         (i_paddr),
		.i_pwdata        (i_pwdata),
		.o_prdata        (o_prdata),
		.o_pready        (o_pready),
		.o_pslverr       (o_pslverr),
		.i_adc_data      (i_adc_data),
		.o_dac_data      (o_dac_data),
		.o_mod_level     (o_mod_level),
		.o_step_sync     (o_step_sync),
		.o_step_sync_dly (o_step_sync_dly),
		.o_rate_sync     (o_rate_sync),
		.o_ramp_sync     (o_ramp_sync)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// sensor sees one constant level per bias half
	always @(posedge i_clk) begin
		#1;
		i_adc_data = o_mod_level ? hi_level[13:0] : lo_level[13:0];
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("** FAIL **");
		$finish;
	end

	ap_pready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_psel && i_penable) |-> o_pready)
		else begin
			$display("FAIL o_pready 0x0 expected 0x1 during an APB access");
			errors++;
		end

	ap_strobe_seq: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_step_sync |=> o_step_sync_dly ##1 o_rate_sync ##1 o_ramp_sync)
		else begin
			$display("strobe sequence after o_step_sync is broken");
			errors++;
		end

	ap_strobe_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0({o_step_sync, o_step_sync_dly, o_rate_sync, o_ramp_sync}))
		else begin
			$display("two sync strobes are high in the same cycle");
			errors++;
		end

	ap_ramp_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_ramp_sync |=> !o_ramp_sync)
		else begin
			$display("o_ramp_sync lasted more than one cycle");
			errors++;
		end

	ap_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		quiet |-> !(o_step_sync || o_step_sync_dly || o_rate_sync || o_ramp_sync))
		else begin
			$display("sync strobe pulsed while the loop was disabled");
			errors++;
		end

	// loop model where rate and ramp phase follow the strobes
	always @(posedge i_clk) begin
		seen_states[UUT.u_demod.state_q] = 1'b1;
		if (quiet) begin
			assert (o_dac_data == 16'h0000 - MOD_AMP) else begin
				$display("FAIL o_dac_data 0x%04h expected 0x%04h", o_dac_data,
					16'h0000 - MOD_AMP);
				errors++;
			end
		end
		if (!loop_on) begin
			model_rate = '0;
			model_phase = '0;
			dac_wait = 0;
		end else begin
			if (o_rate_sync) begin
				model_rate = model_rate + (exp_err >>> gain_cfg);
			end
			if (o_ramp_sync) begin
				model_phase = model_phase + model_rate[15:0];
				dac_wait = 2;
			end else if (o_mod_level != last_level) begin
				dac_wait = 2;
			end else if (dac_wait > 0) begin
				dac_wait--;
				if (dac_wait == 0) begin
					exp_dac = o_mod_level ? model_phase + MOD_AMP : model_phase - MOD_AMP;
					dac_checks++;
					assert (o_dac_data == exp_dac) else begin
						$display("FAIL o_dac_data 0x%04h expected 0x%04h", o_dac_data, exp_dac);
						errors++;
					end
				end
			end
		end
		last_level = o_mod_level;
	end

	task automatic write_reg(input addr_t addr, input word_t data, output logic slverr);
		@(posedge i_clk);
		#1;
		i_psel = 1'b1;
		i_penable = 1'b0;
		i_pwrite = 1'b1;
		i_paddr = addr;
		i_pwdata = data;
		@(posedge i_clk);
		#1;
		i_penable = 1'b1;
		#4;
		slverr = o_pslverr;
		@(posedge i_clk);
		#1;
		i_psel = 1'b0;
		i_penable = 1'b0;
	endtask

	task automatic read_reg(input addr_t addr, output word_t data, output logic slverr);
		@(posedge i_clk);
		#1;
		i_psel = 1'b1;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = addr;
		@(posedge i_clk);
		#1;
		i_penable = 1'b1;
		#4;
		data = o_prdata;
		slverr = o_pslverr;
		@(posedge i_clk);
		#1;
		i_psel = 1'b0;
		i_penable = 1'b0;
	endtask

	task automatic expect_reg(input addr_t addr, input word_t exp, input string name);
		word_t data;
		logic  slverr;
		read_reg(addr, data, slverr);
		assert (data == exp) else begin
			$display("FAIL %s 0x%08h expected 0x%08h", name, data, exp);
			errors++;
		end
		assert (!slverr) else begin
			$display("FAIL o_pslverr 0x1 expected 0x0 reading %s", name);
			errors++;
		end
	endtask

	task automatic stop_loop();
		logic slverr;
		loop_on = 1'b0;
		write_reg(REG_CTRL, 32'd0, slverr);
		repeat (4) @(posedge i_clk);
	endtask

	// levels change only while the loop is stopped
	task automatic start_loop(input int avg, input bit pol, input int gain);
		logic slverr;
		err_t base;
		stop_loop();
		lo_level = int'($urandom % 4096) - 2048;
		hi_level = int'($urandom % 4096) - 2048;
		base = err_t'(hi_level + OFFSET - lo_level);
		exp_err = pol ? -base : base;
		gain_cfg = gain[4:0];
		write_reg(REG_AVG_SEL, word_t'(avg), slverr);
		write_reg(REG_GAIN, word_t'(gain), slverr);
		write_reg(REG_CTRL, {30'd0, pol, 1'b1}, slverr);
		loop_on = 1'b1;
	endtask

	task automatic wait_strobe(input bit ramp);
		int n;
		bit seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < STROBE_TIMEOUT) begin
			@(posedge i_clk);
			seen = ramp ? o_ramp_sync : o_step_sync;
			n++;
		end
		if (!seen) begin
			$display("timed out waiting for %s", ramp ? "o_ramp_sync" : "o_step_sync");
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors != errors_before) begin
			tests_failed++;
			$display("test %-22s failed, %0d errors", name, errors - errors_before);
		end else begin
			$display("test %-22s ok", name);
		end
	endtask

	task automatic reset_and_registers();
		int    e0;
		word_t data;
		logic  slverr;
		e0 = errors;
		assert ({o_step_sync, o_step_sync_dly, o_rate_sync, o_ramp_sync, o_mod_level} == '0)
		else begin
			$display("FAIL sync strobes and o_mod_level 0x%02h expected 0x00 after reset",
				{o_step_sync, o_step_sync_dly, o_rate_sync, o_ramp_sync, o_mod_level});
			errors++;
		end
		write_reg(REG_CTRL, 32'h2, slverr);
		expect_reg(REG_CTRL, 32'h2, "REG_CTRL");
		write_reg(REG_CTRL, 32'h0, slverr);
		write_reg(REG_HALF_PER, word_t'(HALF_PER), slverr);
		expect_reg(REG_HALF_PER, word_t'(HALF_PER), "REG_HALF_PER");
		write_reg(REG_WAIT, word_t'(WAIT_CNT), slverr);
		expect_reg(REG_WAIT, word_t'(WAIT_CNT), "REG_WAIT");
		write_reg(REG_AVG_SEL, 32'd15, slverr);
		expect_reg(REG_AVG_SEL, 32'd10, "REG_AVG_SEL");
		write_reg(REG_OFFSET, word_t'(OFFSET), slverr);
		expect_reg(REG_OFFSET, word_t'(OFFSET), "REG_OFFSET");
		write_reg(REG_GAIN, 32'd31, slverr);
		expect_reg(REG_GAIN, 32'd31, "REG_GAIN");
		write_reg(REG_MOD_AMP, {16'd0, MOD_AMP}, slverr);
		expect_reg(REG_MOD_AMP, {16'd0, MOD_AMP}, "REG_MOD_AMP");
		read_reg(8'h30, data, slverr);
		assert (slverr) else begin
			$display("unmapped read at 0x30 did not raise o_pslverr");
			errors++;
		end
		write_reg(REG_ERR, 32'h1234, slverr);
		assert (slverr) else begin
			$display("write to read-only REG_ERR did not raise o_pslverr");
			errors++;
		end
		finish_test("reset and registers", e0);
	endtask

	task automatic disabled_quiet();
		int e0;
		e0 = errors;
		repeat (2) @(posedge i_clk);
		#1;
		quiet = 1'b1;
		repeat (500) @(posedge i_clk);
		#1;
		quiet = 1'b0;
		expect_reg(REG_CYCLES, 32'd0, "REG_CYCLES");
		finish_test("disabled", e0);
	endtask

	task automatic strobe_sequence();
		int e0;
		e0 = errors;
		start_loop(3, 1'b0, 2);
		repeat (4) begin
			wait_strobe(1'b0);
			wait_strobe(1'b1);
		end
		finish_test("strobe sequence", e0);
	endtask

	task automatic error_values();
		int e0;
		int avgs[3];
		e0 = errors;
		avgs = '{0, 3, 6};
		for (int a = 0; a < 3; a++) begin
			for (int p = 0; p < 2; p++) begin
				start_loop(avgs[a], p[0], 4);
				repeat (2) begin
					wait_strobe(1'b0);
					expect_reg(REG_ERR, word_t'(exp_err), "REG_ERR");
					wait_strobe(1'b1);
				end
			end
		end
		finish_test("error value", e0);
	endtask

	task automatic loop_integration();
		int e0;
		e0 = errors;
		start_loop(3, 1'b0, 3);
		repeat (5) wait_strobe(1'b1);
		expect_reg(REG_RATE, word_t'(err_t'(5) * (exp_err >>> 3)), "REG_RATE");
		expect_reg(REG_CYCLES, 32'd5, "REG_CYCLES");
		finish_test("loop integration", e0);
	endtask

	task automatic dac_tracking();
		int e0;
		int checks0;
		e0 = errors;
		checks0 = dac_checks;
		start_loop(2, 1'b0, 0);
		repeat (8) wait_strobe(1'b1);
		if (dac_checks - checks0 < 16) begin
			$display("only %0d DAC word checks were reached", dac_checks - checks0);
			errors++;
		end
		stop_loop();
		finish_test("dac word", e0);
	endtask

	task automatic report_states();
		demod_state_e st;
		st = st.first();
		for (int i = 0; i < st.num(); i++) begin
			if (!seen_states[st]) begin
				$display("demodulator state %s never reached", st.name());
			end
			st = st.next();
		end
	endtask

	initial begin
		void'($urandom(73361));
		i_rst_n = 1'b0;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		i_adc_data = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		dac_checks = 0;
		dac_wait = 0;
		lo_level = 0;
		hi_level = 0;
		exp_err = '0;
		gain_cfg = '0;
		loop_on = 1'b0;
		quiet = 1'b0;
		last_level = 1'b0;
		seen_states = '0;
		repeat (3) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		reset_and_registers();
		disabled_quiet();
		strobe_sequence();
		error_values();
		loop_integration();
		dac_tracking();
		report_states();
		$display("tests %0d, failed %0d, errors %0d, dac checks %0d",
			tests_run, tests_failed, errors, dac_checks);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/fog_ctrl_top.sv */
/*
 * fog closed-loop controller
 * APB registers, bias modulator, error demodulator and loop filter
 */
`default_nettype none

module fog_ctrl_top #(
	parameter int ADC_BIT = 14,
	parameter int DAC_BIT = 16
) (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_psel,
	input  logic                      i_penable,
	input  logic                      i_pwrite,
	input  fog_pkg::addr_t            i_paddr,
	input  fog_pkg::word_t            i_pwdata,
	output fog_pkg::word_t            o_prdata,
	output logic                      o_pready,
	output logic                      o_pslverr,
	input  logic signed [ADC_BIT-1:0] i_adc_data,
	output logic [DAC_BIT-1:0]        o_dac_data,
	output logic                      o_mod_level,
	output logic                      o_step_sync,
	output logic                      o_step_sync_dly,
	output logic                      o_rate_sync,
	output logic                      o_ramp_sync
);
	import fog_pkg::*;

	// configuration
	logic       enable;
	logic       polarity;
	word_t      half_per;
	word_t      wait_cnt;
	logic [3:0] avg_sel;
	err_t       offset;
	logic [4:0] gain;
	word_t      mod_amp;

	// loop signals
	logic trig;
	err_t err;
	err_t rate;

	fog_apb_regs u_regs (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_psel      (i_psel),
		.i_penable   (i_penable),
		.i_pwrite    (i_pwrite),
		.i_paddr     (i_paddr),
		.i_pwdata    (i_pwdata),
		.i_err       (err),
		.i_err_valid (o_step_sync),
		.i_rate      (rate),
		.o_prdata    (o_prdata),
		.o_pready    (o_pready),
		.o_pslverr   (o_pslverr),
		.o_enable    (enable),
		.o_polarity  (polarity),
		.o_half_per  (half_per),
		.o_wait_cnt  (wait_cnt),
		.o_avg_sel   (avg_sel),
		.o_offset    (offset),
		.o_gain      (gain),
		.o_mod_amp   (mod_amp)
	);

	fog_mod_gen u_mod (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_enable    (enable),
		.i_half_per  (half_per),
		.o_mod_level (o_mod_level),
		.o_trig      (trig)
	);

	fog_err_demod #(
		.ADC_BIT (ADC_BIT)
	) u_demod (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_enable        (enable),
		.i_polarity      (polarity),
		.i_trig          (trig),
		.i_wait_cnt      (wait_cnt),
		.i_offset        (offset),
		.i_adc_data      (i_adc_data),
		.i_avg_sel       (avg_sel),
		.o_err           (err),
		.o_step_sync     (o_step_sync),
		.o_step_sync_dly (o_step_sync_dly),
		.o_rate_sync     (o_rate_sync),
		.o_ramp_sync     (o_ramp_sync)
	);

	fog_loop_filter #(
		.DAC_BIT (DAC_BIT)
	) u_loop (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_err       (err),
		.i_rate_sync (o_rate_sync),
		.i_ramp_sync (o_ramp_sync),
		.i_gain      (gain),
		.i_mod_level (o_mod_level),
		.i_mod_amp   (mod_amp),
		.i_enable    (enable),
		.o_rate      (rate),
		.o_dac_data  (o_dac_data)
	);

endmodule

`default_nettype wire

/* hdl/fog_loop_filter.sv */
/*
 * fog loop filter
 * integrates the error into a rate, advances the serrodyne ramp
 * phase and adds the bias amplitude to form the DAC word
 */
`default_nettype none

module fog_loop_filter #(
	parameter int DAC_BIT = 16
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  fog_pkg::err_t      i_err,
	input  logic               i_rate_sync,
	input  logic               i_ramp_sync,
	input  logic [4:0]         i_gain,
	input  logic               i_mod_level,
	input  fog_pkg::word_t     i_mod_amp,
	input  logic               i_enable,
	output fog_pkg::err_t      o_rate,
	output logic [DAC_BIT-1:0] o_dac_data
);
	import fog_pkg::*;

	err_t               rate_q;
	logic [DAC_BIT-1:0] phase_q;
	logic [DAC_BIT-1:0] amp;
	logic [DAC_BIT-1:0] dac_next;
	err_t               rate_step;

	assign amp       = i_mod_amp[DAC_BIT-1:0];
	assign rate_step = i_err >>> i_gain;
	assign o_rate    = rate_q;

	// bias sits symmetric around the ramp phase, wraps at DAC width
	assign dac_next = i_mod_level ? phase_q + amp : phase_q - amp;

	// rate integrator
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rate_q <= '0;
		end else if (!i_enable) begin
			rate_q <= '0;
		end else if (i_rate_sync) begin
			rate_q <= rate_q + rate_step;
		end
	end

	// ramp phase, low bits of the rate only
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase_q <= '0;
		end else if (!i_enable) begin
			phase_q <= '0;
		end else if (i_ramp_sync) begin
			phase_q <= phase_q + rate_q[DAC_BIT-1:0];
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_dac_data <= '0;
		end else begin
			o_dac_data <= dac_next;
		end
	end

endmodule

`default_nettype wire

/* hdl/fog_err_demod.sv */
/*
 * fog error demodulator
 * settles, averages each bias half and forms the signed error,
 * then issues the step, step-delayed, rate and ramp strobes
 */
`default_nettype none

module fog_err_demod #(
	parameter int ADC_BIT = 14
) (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_enable,
	input  logic                      i_polarity,
	input  logic                      i_trig,
	input  fog_pkg::word_t            i_wait_cnt,
	input  fog_pkg::err_t             i_offset,
	input  logic signed [ADC_BIT-1:0] i_adc_data,
	input  logic [3:0]                i_avg_sel,
	output fog_pkg::err_t             o_err,
	output logic                      o_step_sync,
	output logic                      o_step_sync_dly,
	output logic                      o_rate_sync,
	output logic                      o_ramp_sync
);
	import fog_pkg::*;

	demod_state_e state_q;
	demod_state_e state_d;
	logic         r_enable;
	logic         r_trig;
	adc_t         r_adc;
	word_t        settle_cnt;
	logic [10:0]  acc_cnt;
	logic [3:0]   shift_q;
	err_t         sum;
	err_t         lo_avg;
	err_t         hi_avg;
	err_t         err_q;
	logic         start_acq;
	logic         settle_done;
	logic         acc_done;

	assign start_acq   = r_trig && (state_q == WAIT_LO || state_q == WAIT_HI);
	assign settle_done = (settle_cnt == '0);
	assign acc_done    = (acc_cnt == '0);
	assign o_err       = err_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			// first boundary after enable is the rise into the high half
			IDLE:      if (r_trig) state_d = WAIT_LO;
			WAIT_LO:   if (r_trig) state_d = SETTLE_LO;
			SETTLE_LO: if (settle_done) state_d = ACQ_LO;
			ACQ_LO:    if (acc_done) state_d = WAIT_HI;
			WAIT_HI:   if (r_trig) state_d = SETTLE_HI;
			SETTLE_HI: if (settle_done) state_d = ACQ_HI;
			ACQ_HI:    if (acc_done) state_d = ERR_GEN;
			ERR_GEN:   state_d = ERR_DLY;
			ERR_DLY:   state_d = RATE_SYNC;
			RATE_SYNC: state_d = RAMP_SYNC;
			RAMP_SYNC: state_d = NEXT;
			NEXT:      state_d = WAIT_LO;
			default:   state_d = IDLE;
		endcase
		if (!r_enable) begin
			state_d = IDLE;
		end
	end

	// sample path, window length and shift are latched per acquisition
	always_ff @(posedge i_clk) begin
		r_adc <= i_adc_data;
		if (start_acq) begin
			settle_cnt <= i_wait_cnt;
			acc_cnt    <= 11'd1 << i_avg_sel;
			shift_q    <= i_avg_sel;
			sum        <= '0;
		end else if (state_q == SETTLE_LO || state_q == SETTLE_HI) begin
			if (!settle_done) begin
				settle_cnt <= settle_cnt - word_t'(1);
			end
		end else if ((state_q == ACQ_LO || state_q == ACQ_HI) && !acc_done) begin
			acc_cnt <= acc_cnt - 11'd1;
			sum     <= sum + err_t'(r_adc);
		end
		// done cycle, the window sum is complete
		if (state_q == ACQ_LO && acc_done) begin
			lo_avg <= sum >>> shift_q;
		end
		if (state_q == ACQ_HI && acc_done) begin
			hi_avg <= (sum >>> shift_q) + i_offset;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_enable        <= 1'b0;
			r_trig          <= 1'b0;
			state_q         <= IDLE;
			err_q           <= '0;
			o_step_sync     <= 1'b0;
			o_step_sync_dly <= 1'b0;
			o_rate_sync     <= 1'b0;
			o_ramp_sync     <= 1'b0;
		end else begin
			r_enable        <= i_enable;
			r_trig          <= i_trig;
			state_q         <= state_d;
			o_step_sync     <= r_enable && (state_q == ERR_GEN);
			o_step_sync_dly <= r_enable && (state_q == ERR_DLY);
			o_rate_sync     <= r_enable && (state_q == RATE_SYNC);
			o_ramp_sync     <= r_enable && (state_q == RAMP_SYNC);
			if (r_enable && state_q == ERR_GEN) begin
				err_q <= i_polarity ? lo_avg - hi_avg : hi_avg - lo_avg;
			end
		end
	end

	ap_strobe_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0({o_step_sync, o_step_sync_dly, o_rate_sync, o_ramp_sync}))
		else $error("demodulator strobes overlap");

	// each strobe is only ever the successor of the one before
	ap_dly_after_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_step_sync_dly |-> $past(o_step_sync))
		else $error("step_sync_dly without step_sync");

	ap_rate_after_dly: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_rate_sync |-> $past(o_step_sync_dly))
		else $error("rate_sync without step_sync_dly");

	ap_ramp_after_rate: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_ramp_sync |-> $past(o_rate_sync))
		else $error("ramp_sync without rate_sync");

endmodule

`default_nettype wire

/* hdl/fog_mod_gen.sv */
/*
 * fog bias modulation generator
 * square-wave bias level with a trigger on every half-period boundary
 */
`default_nettype none

module fog_mod_gen (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  logic           i_enable,
	input  fog_pkg::word_t i_half_per,
	output logic           o_mod_level,
	output logic           o_trig
);
	import fog_pkg::*;

	word_t cnt;
	word_t half_len;
	logic  boundary;

	// half-periods below two clocks run at two
	assign half_len = (i_half_per < word_t'(2)) ? word_t'(2) : i_half_per;

	// >= so a shorter half_per written mid-count still ends the period
	assign boundary = (cnt >= half_len - word_t'(1));

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt         <= '0;
			o_mod_level <= 1'b0;
			o_trig      <= 1'b0;
		end else if (!i_enable) begin
			cnt         <= '0;
			o_mod_level <= 1'b0;
			o_trig      <= 1'b0;
		end else begin
			o_trig <= boundary;
			if (boundary) begin
				cnt         <= '0;
				o_mod_level <= ~o_mod_level;
			end else begin
				cnt <= cnt + word_t'(1);
			end
		end
	end

	ap_trig_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_trig |=> !o_trig)
		else $error("modulation trigger longer than one cycle");

endmodule

`default_nettype wire

/* hdl/fog_apb_regs.sv */
/*
 * fog APB register slave
 * holds loop configuration and exposes error, rate and cycle count
 */
`default_nettype none

module fog_apb_regs (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  logic           i_psel,
	input  logic           i_penable,
	input  logic           i_pwrite,
	input  fog_pkg::addr_t i_paddr,
	input  fog_pkg::word_t i_pwdata,
	input  fog_pkg::err_t  i_err,
	input  logic           i_err_valid,
	input  fog_pkg::err_t  i_rate,
	output fog_pkg::word_t o_prdata,
	output logic           o_pready,
	output logic           o_pslverr,
	output logic           o_enable,
	output logic           o_polarity,
	output fog_pkg::word_t o_half_per,
	output fog_pkg::word_t o_wait_cnt,
	output logic [3:0]     o_avg_sel,
	output fog_pkg::err_t  o_offset,
	output logic [4:0]     o_gain,
	output fog_pkg::word_t o_mod_amp
);
	import fog_pkg::*;

	logic  access;
	logic  addr_hit;
	logic  read_only;
	logic  wr_en;
	word_t rd_data;
	err_t  err_snap;
	word_t cycles;

	assign access = i_psel & i_penable;

	// address decode and read mux
	always_comb begin
		addr_hit  = 1'b1;
		read_only = 1'b0;
		rd_data   = '0;
		case (i_paddr)
			REG_CTRL:     rd_data = {30'd0, o_polarity, o_enable};
			REG_HALF_PER: rd_data = o_half_per;
			REG_WAIT:     rd_data = o_wait_cnt;
			REG_AVG_SEL:  rd_data = {28'd0, o_avg_sel};
			REG_OFFSET:   rd_data = word_t'(o_offset);
			REG_GAIN:     rd_data = {27'd0, o_gain};
			REG_MOD_AMP:  rd_data = o_mod_amp;
			REG_ERR: begin
				rd_data   = word_t'(err_snap);
				read_only = 1'b1;
			end
			REG_RATE: begin
				rd_data   = word_t'(i_rate);
				read_only = 1'b1;
			end
			REG_CYCLES: begin
				rd_data   = cycles;
				read_only = 1'b1;
			end
			default: addr_hit = 1'b0;
		endcase
	end

	assign wr_en     = access & i_pwrite & addr_hit & ~read_only;
	assign o_prdata  = access ? rd_data : '0;
	assign o_pready  = 1'b1;
	assign o_pslverr = access & (~addr_hit | (i_pwrite & read_only));

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_enable   <= 1'b0;
			o_polarity <= 1'b0;
			o_half_per <= '0;
			o_wait_cnt <= '0;
			o_avg_sel  <= '0;
			o_offset   <= '0;
			o_gain     <= '0;
			o_mod_amp  <= '0;
		end else if (wr_en) begin
			case (i_paddr)
				REG_CTRL: begin
					o_enable   <= i_pwdata[0];
					o_polarity <= i_pwdata[1];
				end
				REG_HALF_PER: o_half_per <= i_pwdata;
				REG_WAIT:     o_wait_cnt <= i_pwdata;
				// anything past 1024 samples saturates
				REG_AVG_SEL:  o_avg_sel <= (i_pwdata > word_t'(avg_sel_max)) ?
					avg_sel_max : i_pwdata[3:0];
				REG_OFFSET:   o_offset <= err_t'(i_pwdata);
				REG_GAIN:     o_gain <= i_pwdata[4:0];
				REG_MOD_AMP:  o_mod_amp <= i_pwdata;
				default: ;
			endcase
		end
	end

	// error snapshot and a cycle count that restarts with each enable
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			err_snap <= '0;
			cycles   <= '0;
		end else begin
			if (i_err_valid) begin
				err_snap <= i_err;
			end
			if (!o_enable) begin
				cycles <= '0;
			end else if (i_err_valid) begin
				cycles <= cycles + word_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/fog_pkg.sv */
/*
 * fog core package
 * shared sample and word types, APB register map and demodulator states
 */
`default_nettype none

package fog_pkg;

	// widest ADC sample the demodulator accepts
	localparam int adc_max_w = 16;

	typedef logic signed [adc_max_w-1:0] adc_t;
	typedef logic signed [31:0] err_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0] addr_t;

	// configuration registers
	localparam addr_t REG_CTRL     = 8'h00;
	localparam addr_t REG_HALF_PER = 8'h04;
	localparam addr_t REG_WAIT     = 8'h08;
	localparam addr_t REG_AVG_SEL  = 8'h0C;
	localparam addr_t REG_OFFSET   = 8'h10;
	localparam addr_t REG_GAIN     = 8'h14;
	localparam addr_t REG_MOD_AMP  = 8'h18;

	// read-only status
	localparam addr_t REG_ERR    = 8'h20;
	localparam addr_t REG_RATE   = 8'h24;
	localparam addr_t REG_CYCLES = 8'h28;

	// largest averaging exponent, 1024 samples
	localparam logic [3:0] avg_sel_max = 4'd10;

	typedef enum logic [3:0] {
		IDLE, WAIT_LO, SETTLE_LO, ACQ_LO,
		WAIT_HI, SETTLE_HI, ACQ_HI,
		ERR_GEN, ERR_DLY, RATE_SYNC, RAMP_SYNC, NEXT
	} demod_state_e;

endpackage

`default_nettype wire
